/* project.f */
rtl/gaa_pkg.sv
rtl/fitness_ifs.sv
rtl/host_regs.sv
rtl/sdram_master.sv
rtl/partition_lookup.sv
rtl/cut_counter.sv
rtl/gaa_fitness.sv
sim/sdram_model.sv
sim/tb_gaa_fitness.sv

/* rtl/cut_counter.sv */
module cut_counter #(
	parameter int NUM_IDV = gaa_pkg::NUM_IDV_DEF
) (
	input logic clk,
	input logic reset,
	input logic start,
	diff_if.sink diff_in,
	input logic [$clog2(NUM_IDV)-1:0] rd_index,
	output gaa_pkg::count_t rd_count,
	output logic counts_ready
);

	gaa_pkg::count_t counts [NUM_IDV];

	// every individual keeps its own running cut size
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_IDV; i++) begin
			if (start) begin
				counts[i] <= '0;
			end else if (diff_in.valid) begin
				counts[i] <= counts[i] + gaa_pkg::count_t'(diff_in.diff[i]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			counts_ready <= 1'b0;
		end else if (start) begin
			counts_ready <= 1'b0;
		end else if (diff_in.valid && diff_in.last) begin
			counts_ready <= 1'b1;
		end
	end

	assign rd_count = counts[rd_index];

	// counts are final once ready, nothing may still be in flight
	no_late_beat_a: assert property (@(posedge clk) disable iff (reset)
		counts_ready |-> !diff_in.valid);

endmodule

/* rtl/fitness_ifs.sv */
// one node pair per beat, no back-pressure
interface edge_if #(
	parameter int NODE_W = gaa_pkg::NODE_W_DEF
) ();

	logic valid;
	logic [NODE_W-1:0] node_a;
	logic [NODE_W-1:0] node_b;
	logic last;

	modport source (
		output valid,
		output node_a,
		output node_b,
		output last
	);

	modport sink (
		input valid,
		input node_a,
		input node_b,
		input last
	);

endinterface

// one bit per individual, set where the edge crosses that cut
interface diff_if #(
	parameter int NUM_IDV = gaa_pkg::NUM_IDV_DEF
) ();

	logic valid;
	logic [NUM_IDV-1:0] diff;
	logic last;

	modport source (
		output valid,
		output diff,
		output last
	);

	modport sink (
		input valid,
		input diff,
		input last
	);

endinterface

/* rtl/gaa_fitness.sv */
module gaa_fitness #(
	parameter int NUM_IDV = gaa_pkg::NUM_IDV_DEF,
	parameter int NODE_W = gaa_pkg::NODE_W_DEF,
	parameter gaa_pkg::sdram_addr_t FITNESS_BASE = gaa_pkg::FITNESS_BASE_DEF
) (
	input logic clk,
	input logic reset,

	// host slave
	input logic [3:0] hps_address,
	input logic hps_chipselect,
	input logic hps_write,
	input gaa_pkg::host_byte_t hps_writedata,
	input logic hps_read,
	output gaa_pkg::host_byte_t hps_readdata,
	output logic hps_waitrequest,

	// sdram master
	output gaa_pkg::sdram_addr_t sdram_address,
	output logic [1:0] sdram_byteenable_n,
	output logic sdram_chipselect,
	output logic sdram_read_n,
	output logic sdram_write_n,
	output gaa_pkg::sdram_word_t sdram_writedata,
	input gaa_pkg::sdram_word_t sdram_readdata,
	input logic sdram_readdatavalid,
	input logic sdram_waitrequest
);

	localparam int IDX_W = $clog2(NUM_IDV);

	gaa_pkg::edge_count_t num_edges;
	gaa_pkg::host_byte_t num_idv;
	gaa_pkg::count_t rd_count;
	logic pop_wren;
	logic [NODE_W-1:0] pop_row;
	logic [NUM_IDV-1:0] pop_data;
	logic start;
	logic done;
	logic counts_ready;
	logic [IDX_W-1:0] rd_index;

	edge_if #(.NODE_W(NODE_W)) edge_bus ();
	diff_if #(.NUM_IDV(NUM_IDV)) diff_bus ();

	host_regs #(
		.NUM_IDV(NUM_IDV),
		.NODE_W(NODE_W)
	) u_host_regs (
		.clk(clk),
		.reset(reset),
		.hps_address(hps_address),
		.hps_chipselect(hps_chipselect),
		.hps_write(hps_write),
		.hps_writedata(hps_writedata),
		.hps_read(hps_read),
		.done(done),
		.hps_readdata(hps_readdata),
		.hps_waitrequest(hps_waitrequest),
		.num_edges(num_edges),
		.num_idv(num_idv),
		.pop_wren(pop_wren),
		.pop_row(pop_row),
		.pop_data(pop_data),
		.start(start)
	);

	sdram_master #(
		.NODE_W(NODE_W),
		.NUM_IDV(NUM_IDV),
		.FITNESS_BASE(FITNESS_BASE)
	) u_sdram_master (
		.clk(clk),
		.reset(reset),
		.start(start),
		.num_edges(num_edges),
		.num_idv(num_idv),
		.counts_ready(counts_ready),
		.rd_count(rd_count),
		.sdram_readdata(sdram_readdata),
		.sdram_readdatavalid(sdram_readdatavalid),
		.sdram_waitrequest(sdram_waitrequest),
		.edge_out(edge_bus.source),
		.rd_index(rd_index),
		.done(done),
		.sdram_address(sdram_address),
		.sdram_byteenable_n(sdram_byteenable_n),
		.sdram_chipselect(sdram_chipselect),
		.sdram_read_n(sdram_read_n),
		.sdram_write_n(sdram_write_n),
		.sdram_writedata(sdram_writedata)
	);

	partition_lookup #(
		.NUM_IDV(NUM_IDV),
		.NODE_W(NODE_W)
	) u_partition_lookup (
		.clk(clk),
		.reset(reset),
		.pop_wren(pop_wren),
		.pop_row(pop_row),
		.pop_data(pop_data),
		.edge_in(edge_bus.sink),
		.diff_out(diff_bus.source)
	);

	cut_counter #(
		.NUM_IDV(NUM_IDV)
	) u_cut_counter (
		.clk(clk),
		.reset(reset),
		.start(start),
		.diff_in(diff_bus.sink),
		.rd_index(rd_index),
		.rd_count(rd_count),
		.counts_ready(counts_ready)
	);

endmodule

/* rtl/gaa_pkg.sv */
package gaa_pkg;

	// default problem size
	localparam int NUM_IDV_DEF = 16;
	localparam int NODE_W_DEF = 8;

	localparam int COUNT_W = 16;
	localparam int SDRAM_ADDR_W = 25;

	typedef logic [SDRAM_ADDR_W-1:0] sdram_addr_t;
	typedef logic [15:0] sdram_word_t;
	typedef logic [7:0] host_byte_t;
	typedef logic [15:0] edge_count_t;
	typedef logic [COUNT_W-1:0] count_t;

	// results start halfway through the sdram, edges fill the lower half
	localparam sdram_addr_t FITNESS_BASE_DEF = 25'h100_0000;

	// host register map
	localparam logic [3:0] REG_EDGES_LO = 4'd0;
	localparam logic [3:0] REG_EDGES_HI = 4'd1;
	localparam logic [3:0] REG_NUM_IDV = 4'd2;
	localparam logic [3:0] REG_POP_BYTE = 4'd3;
	localparam logic [3:0] REG_START = 4'd4;

endpackage

/* rtl/host_regs.sv */
module host_regs #(
	parameter int NUM_IDV = gaa_pkg::NUM_IDV_DEF,
	parameter int NODE_W = gaa_pkg::NODE_W_DEF
) (
	input logic clk,
	input logic reset,
	input logic [3:0] hps_address,
	input logic hps_chipselect,
	input logic hps_write,
	input gaa_pkg::host_byte_t hps_writedata,
	input logic hps_read,
	input logic done,
	output gaa_pkg::host_byte_t hps_readdata,
	output logic hps_waitrequest,
	output gaa_pkg::edge_count_t num_edges,
	output gaa_pkg::host_byte_t num_idv,
	output logic pop_wren,
	output logic [NODE_W-1:0] pop_row,
	output logic [NUM_IDV-1:0] pop_data,
	output logic start
);

	localparam int ROW_BYTES = NUM_IDV / 8;
	localparam int BYTE_CNT_W = (ROW_BYTES > 1) ? $clog2(ROW_BYTES) : 1;

	logic busy;
	logic access;
	logic row_full;
	logic [BYTE_CNT_W-1:0] byte_cnt;
	logic [NODE_W-1:0] row_ptr;

	// host stalls for the whole run
	assign hps_waitrequest = busy;
	assign access = hps_chipselect && hps_write && !busy;
	assign row_full = (byte_cnt == BYTE_CNT_W'(ROW_BYTES - 1));

	always_comb begin
		hps_readdata = '0;
		if (hps_chipselect && hps_read) begin
			case (hps_address)
				gaa_pkg::REG_EDGES_LO: hps_readdata = num_edges[7:0];
				gaa_pkg::REG_EDGES_HI: hps_readdata = num_edges[15:8];
				gaa_pkg::REG_NUM_IDV: hps_readdata = num_idv;
				default: hps_readdata = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			start <= 1'b0;
			pop_wren <= 1'b0;
			byte_cnt <= '0;
			row_ptr <= '0;
			num_edges <= '0;
			num_idv <= '0;
		end else begin
			start <= 1'b0;
			pop_wren <= 1'b0;
			if (done) begin
				busy <= 1'b0;
			end
			if (access) begin
				case (hps_address)
					gaa_pkg::REG_EDGES_LO: num_edges[7:0] <= hps_writedata;
					gaa_pkg::REG_EDGES_HI: num_edges[15:8] <= hps_writedata;
					gaa_pkg::REG_NUM_IDV: num_idv <= hps_writedata;
					gaa_pkg::REG_POP_BYTE: begin
						if (row_full) begin
							byte_cnt <= '0;
							pop_wren <= 1'b1;
							row_ptr <= row_ptr + 1'b1;
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
					gaa_pkg::REG_START: begin
						start <= 1'b1;
						busy <= 1'b1;
						byte_cnt <= '0;
						row_ptr <= '0;
					end
					default: ;
				endcase
			end
		end
	end

	// bytes shift in from the top, so the first one ends up lowest
	always_ff @(posedge clk) begin
		if (access && hps_address == gaa_pkg::REG_POP_BYTE) begin
			pop_data <= (pop_data >> 8) | (NUM_IDV'(hps_writedata) << (NUM_IDV - 8));
			pop_row <= row_ptr;
		end
	end

	// a run only ends while the host is held off, so start cannot overlap it
	done_in_run_a: assert property (@(posedge clk) disable iff (reset)
		done |-> busy);

endmodule

/* rtl/partition_lookup.sv */
module partition_lookup #(
	parameter int NUM_IDV = gaa_pkg::NUM_IDV_DEF,
	parameter int NODE_W = gaa_pkg::NODE_W_DEF
) (
	input logic clk,
	input logic reset,
	input logic pop_wren,
	input logic [NODE_W-1:0] pop_row,
	input logic [NUM_IDV-1:0] pop_data,
	edge_if.sink edge_in,
	diff_if.source diff_out
);

	// one row per node, bit i is the side individual i picks
	logic [NUM_IDV-1:0] pop_mem [2**NODE_W];

	logic [NODE_W-1:0] addr_a;
	logic [NODE_W-1:0] addr_b;
	logic [NUM_IDV-1:0] row_a;
	logic [NUM_IDV-1:0] row_b;
	logic valid_1;
	logic last_1;
	logic valid_2;
	logic last_2;

	always_ff @(posedge clk) begin
		if (pop_wren) begin
			pop_mem[pop_row] <= pop_data;
		end
	end

	always_ff @(posedge clk) begin
		if (edge_in.valid) begin
			addr_a <= edge_in.node_a;
			addr_b <= edge_in.node_b;
		end
		row_a <= pop_mem[addr_a];
		row_b <= pop_mem[addr_b];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_1 <= 1'b0;
			last_1 <= 1'b0;
			valid_2 <= 1'b0;
			last_2 <= 1'b0;
		end else begin
			valid_1 <= edge_in.valid;
			last_1 <= edge_in.valid && edge_in.last;
			valid_2 <= valid_1;
			last_2 <= last_1;
		end
	end

	// differing sides mean the edge is cut
	assign diff_out.diff = row_a ^ row_b;
	assign diff_out.valid = valid_2;
	assign diff_out.last = last_2;

endmodule

/* rtl/sdram_master.sv */
module sdram_master #(
	parameter int NODE_W = gaa_pkg::NODE_W_DEF,
	parameter int NUM_IDV = gaa_pkg::NUM_IDV_DEF,
	parameter gaa_pkg::sdram_addr_t FITNESS_BASE = gaa_pkg::FITNESS_BASE_DEF
) (
	input logic clk,
	input logic reset,
	input logic start,
	input gaa_pkg::edge_count_t num_edges,
	input gaa_pkg::host_byte_t num_idv,
	input logic counts_ready,
	input gaa_pkg::count_t rd_count,
	input gaa_pkg::sdram_word_t sdram_readdata,
	input logic sdram_readdatavalid,
	input logic sdram_waitrequest,
	edge_if.source edge_out,
	output logic [$clog2(NUM_IDV)-1:0] rd_index,
	output logic done,
	output gaa_pkg::sdram_addr_t sdram_address,
	output logic [1:0] sdram_byteenable_n,
	output logic sdram_chipselect,
	output logic sdram_read_n,
	output logic sdram_write_n,
	output gaa_pkg::sdram_word_t sdram_writedata
);

	localparam int CNT_W = $clog2(NUM_IDV + 1);
	localparam int IDX_W = $clog2(NUM_IDV);

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ_A,
		S_READ_B,
		S_DRAIN,
		S_WRITE,
		S_FINISH
	} master_state_t;

	master_state_t state;
	gaa_pkg::edge_count_t edge_idx;
	logic pending;
	logic accepted;
	logic last_edge;
	logic [NODE_W-1:0] node_a;
	logic [CNT_W-1:0] wr_cnt;
	logic [CNT_W-1:0] wr_limit;

	assign accepted = sdram_chipselect && !sdram_waitrequest;
	assign last_edge = (edge_idx == num_edges - 1'b1);
	// never write back more individuals than the table holds
	assign wr_limit = (num_idv >= NUM_IDV) ? CNT_W'(NUM_IDV) : CNT_W'(num_idv);
	assign rd_index = wr_cnt[IDX_W-1:0];
	assign done = (state == S_FINISH);
	assign sdram_byteenable_n = 2'b00;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			pending <= 1'b0;
			sdram_chipselect <= 1'b0;
			sdram_read_n <= 1'b1;
			sdram_write_n <= 1'b1;
			edge_out.valid <= 1'b0;
		end else begin
			edge_out.valid <= 1'b0;
			if (accepted) begin
				sdram_chipselect <= 1'b0;
				sdram_read_n <= 1'b1;
				sdram_write_n <= 1'b1;
			end
			case (state)
				S_IDLE: begin
					if (start) begin
						edge_idx <= '0;
						sdram_address <= '0;
						sdram_chipselect <= 1'b1;
						sdram_read_n <= 1'b0;
						state <= S_READ_A;
					end
				end
				S_READ_A: begin
					if (accepted) begin
						pending <= 1'b1;
					end
					if (pending && sdram_readdatavalid) begin
						pending <= 1'b0;
						node_a <= sdram_readdata[NODE_W-1:0];
						sdram_address <= sdram_address + 1'b1;
						sdram_chipselect <= 1'b1;
						sdram_read_n <= 1'b0;
						state <= S_READ_B;
					end
				end
				S_READ_B: begin
					if (accepted) begin
						pending <= 1'b1;
					end
					if (pending && sdram_readdatavalid) begin
						pending <= 1'b0;
						edge_out.valid <= 1'b1;
						edge_out.node_a <= node_a;
						edge_out.node_b <= sdram_readdata[NODE_W-1:0];
						edge_out.last <= last_edge;
						if (last_edge) begin
							state <= S_DRAIN;
						end else begin
							// next pair follows directly in memory
							edge_idx <= edge_idx + 1'b1;
							sdram_address <= sdram_address + 1'b1;
							sdram_chipselect <= 1'b1;
							sdram_read_n <= 1'b0;
							state <= S_READ_A;
						end
					end
				end
				S_DRAIN: begin
					// wait for the lookup and counter pipeline to empty
					if (counts_ready) begin
						wr_cnt <= '0;
						state <= S_WRITE;
					end
				end
				S_WRITE: begin
					if (accepted) begin
						wr_cnt <= wr_cnt + 1'b1;
					end else if (!sdram_chipselect) begin
						if (wr_cnt == wr_limit) begin
							state <= S_FINISH;
						end else begin
							sdram_address <= FITNESS_BASE + gaa_pkg::SDRAM_ADDR_W'(wr_cnt);
							sdram_writedata <= rd_count;
							sdram_chipselect <= 1'b1;
							sdram_write_n <= 1'b0;
						end
					end
				end
				S_FINISH: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	rw_exclusive_a: assert property (@(posedge clk) disable iff (reset)
		!(!sdram_read_n && !sdram_write_n));

	addr_hold_a: assert property (@(posedge clk) disable iff (reset)
		sdram_chipselect && sdram_waitrequest |=> sdram_chipselect && $stable(sdram_address));

endmodule

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log shows the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_gaa_fitness \
	-f project.f -Mdir obj_dir -o sim_gaa_fitness &&
./obj_dir/sim_gaa_fitness > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sim/sdram_model.sv */
module sdram_model #(
	parameter logic [31:0] SEED = 32'hd12e_56fa,
	parameter int LAT_MAX = 4
) (
	input logic clk,
	input logic reset,
	input logic rand_en,
	input gaa_pkg::sdram_addr_t sdram_address,
	input logic [1:0] sdram_byteenable_n,
	input logic sdram_chipselect,
	input logic sdram_read_n,
	input logic sdram_write_n,
	input gaa_pkg::sdram_word_t sdram_writedata,
	output gaa_pkg::sdram_word_t sdram_readdata,
	output logic sdram_readdatavalid,
	output logic sdram_waitrequest
);

	// sparse storage, untouched words read back a pattern of their address
	gaa_pkg::sdram_word_t mem [gaa_pkg::sdram_addr_t];

	integer seed;
	int wait_left;
	logic new_read;
	logic rand_now;
	gaa_pkg::sdram_word_t rd_word;

	function automatic gaa_pkg::sdram_word_t peek(input gaa_pkg::sdram_addr_t addr);
		if (mem.exists(addr)) begin
			return mem[addr];
		end
		return gaa_pkg::sdram_word_t'(addr) ^ gaa_pkg::sdram_word_t'(addr >> 16) ^ 16'h5a3c;
	endfunction

	function automatic void poke(input gaa_pkg::sdram_addr_t addr,
			input gaa_pkg::sdram_word_t data);
		mem[addr] = data;
	endfunction

	initial begin
		seed = SEED;
		wait_left = 0;
		new_read = 1'b0;
		rand_now = 1'b0;
		rd_word = '0;
		sdram_readdata = '0;
		sdram_readdatavalid = 1'b0;
		sdram_waitrequest = 1'b0;
	end

	always @(negedge clk) begin
		gaa_pkg::sdram_word_t word;
		// the request exactly as the master sees it at the coming edge
		rand_now = rand_en;
		new_read = sdram_chipselect && !sdram_waitrequest && !sdram_read_n;
		if (sdram_chipselect && !sdram_waitrequest && !sdram_write_n) begin
			word = peek(sdram_address);
			if (!sdram_byteenable_n[0]) begin
				word[7:0] = sdram_writedata[7:0];
			end
			if (!sdram_byteenable_n[1]) begin
				word[15:8] = sdram_writedata[15:8];
			end
			mem[sdram_address] = word;
		end
		if (new_read) begin
			rd_word = peek(sdram_address);
		end
		@(posedge clk);
		#1;
		sdram_readdatavalid = 1'b0;
		if (reset) begin
			wait_left = 0;
			sdram_waitrequest = 1'b0;
		end else begin
			if (new_read) begin
				wait_left = rand_now ? 1 + int'($unsigned($random(seed)) % LAT_MAX) : 1;
			end
			if (wait_left > 0) begin
				wait_left--;
				if (wait_left == 0) begin
					sdram_readdatavalid = 1'b1;
					sdram_readdata = rd_word;
				end
			end
			sdram_waitrequest = rand_now && (($random(seed) & 1) != 0);
		end
	end

endmodule

/* sim/tb_gaa_fitness.sv */
module tb_gaa_fitness;

	localparam int NUM_IDV = gaa_pkg::NUM_IDV_DEF;
	localparam int NODE_W = gaa_pkg::NODE_W_DEF;
	localparam gaa_pkg::sdram_addr_t FITNESS_BASE = gaa_pkg::FITNESS_BASE_DEF;
	localparam int ROWS = 2 ** NODE_W;
	localparam int ROW_BYTES = NUM_IDV / 8;
	localparam int PERIOD = 4;
	localparam logic [31:0] SEED = 32'hd12e_56fa;
	localparam int EXTRA_WORDS = 4;
	localparam int PARTIAL_IDV = 5;

	// edge counts per test, they size the watchdog
	localparam int EDGES_SINGLE = 1;
	localparam int EDGES_RANDOM = 40;
	localparam int EDGES_RERUN = 23;
	localparam int MAX_EDGES = 64;
	localparam int TOTAL_EDGES = EDGES_SINGLE + 3 * EDGES_RANDOM + EDGES_RERUN;
	localparam int NUM_RUNS = 5;
	localparam int NUM_LOADS = 2;
	localparam int WATCHDOG_CYCLES = TOTAL_EDGES * 64 + NUM_LOADS * ROWS * ROW_BYTES * 4
		+ NUM_RUNS * 400 + 1000;

	logic clk;
	logic reset;
	logic rand_en;
	logic [3:0] hps_address;
	logic hps_chipselect;
	logic hps_write;
	gaa_pkg::host_byte_t hps_writedata;
	logic hps_read;
	gaa_pkg::host_byte_t hps_readdata;
	logic hps_waitrequest;
	gaa_pkg::sdram_addr_t sdram_address;
	logic [1:0] sdram_byteenable_n;
	logic sdram_chipselect;
	logic sdram_read_n;
	logic sdram_write_n;
	gaa_pkg::sdram_word_t sdram_writedata;
	gaa_pkg::sdram_word_t sdram_readdata;
	logic sdram_readdatavalid;
	logic sdram_waitrequest;

	integer seed;
	int errors;
	int tests_run;
	int failed_tests;
	int stall_cycles;
	int edge_total;
	logic [NUM_IDV-1:0] pop_rows [ROWS];
	logic [NODE_W-1:0] edge_a [MAX_EDGES];
	logic [NODE_W-1:0] edge_b [MAX_EDGES];
	int exp_counts [NUM_IDV];

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	gaa_fitness #(
		.NUM_IDV(NUM_IDV),
		.NODE_W(NODE_W),
		.FITNESS_BASE(FITNESS_BASE)
	) u_gaa_fitness (
		.clk(clk),
		.reset(reset),
		.hps_address(hps_address),
		.hps_chipselect(hps_chipselect),
		.hps_write(hps_write),
		.hps_writedata(hps_writedata),
		.hps_read(hps_read),
		.hps_readdata(hps_readdata),
		.hps_waitrequest(hps_waitrequest),
		.sdram_address(sdram_address),
		.sdram_byteenable_n(sdram_byteenable_n),
		.sdram_chipselect(sdram_chipselect),
		.sdram_read_n(sdram_read_n),
		.sdram_write_n(sdram_write_n),
		.sdram_writedata(sdram_writedata),
		.sdram_readdata(sdram_readdata),
		.sdram_readdatavalid(sdram_readdatavalid),
		.sdram_waitrequest(sdram_waitrequest)
	);

	sdram_model #(
		.SEED(SEED)
	) u_sdram_model (
		.clk(clk),
		.reset(reset),
		.rand_en(rand_en),
		.sdram_address(sdram_address),
		.sdram_byteenable_n(sdram_byteenable_n),
		.sdram_chipselect(sdram_chipselect),
		.sdram_read_n(sdram_read_n),
		.sdram_write_n(sdram_write_n),
		.sdram_writedata(sdram_writedata),
		.sdram_readdata(sdram_readdata),
		.sdram_readdatavalid(sdram_readdatavalid),
		.sdram_waitrequest(sdram_waitrequest)
	);

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("%s: passed", name);
		end else begin
			failed_tests++;
			$display("%s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	// waitrequest is registered, so the negedge value is what the next edge sees
	task automatic host_write(input logic [3:0] addr, input gaa_pkg::host_byte_t data);
		hps_address = addr;
		hps_writedata = data;
		hps_chipselect = 1'b1;
		hps_write = 1'b1;
		stall_cycles = 0;
		@(negedge clk);
		while (hps_waitrequest) begin
			stall_cycles++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		hps_chipselect = 1'b0;
		hps_write = 1'b0;
	endtask

	task automatic host_read(input logic [3:0] addr, output gaa_pkg::host_byte_t data);
		hps_address = addr;
		hps_chipselect = 1'b1;
		hps_read = 1'b1;
		@(negedge clk);
		while (hps_waitrequest) begin
			@(negedge clk);
		end
		data = hps_readdata;
		@(posedge clk);
		#1;
		hps_chipselect = 1'b0;
		hps_read = 1'b0;
	endtask

	function automatic gaa_pkg::sdram_word_t preset_word(input int i);
		return gaa_pkg::sdram_word_t'(32'hc000 + 257 * i);
	endfunction

	task automatic preset_results();
		for (int i = 0; i < NUM_IDV + EXTRA_WORDS; i++) begin
			u_sdram_model.poke(FITNESS_BASE + gaa_pkg::sdram_addr_t'(i), preset_word(i));
		end
	endtask

	// low byte of each row goes first
	task automatic load_population();
		for (int r = 0; r < ROWS; r++) begin
			for (int b = 0; b < ROW_BYTES; b++) begin
				host_write(gaa_pkg::REG_POP_BYTE, pop_rows[r][8*b +: 8]);
			end
		end
	endtask

	task automatic random_population();
		for (int r = 0; r < ROWS; r++) begin
			pop_rows[r] = NUM_IDV'($random(seed));
		end
	endtask

	// upper bits of each word are noise the DUT has to ignore
	task automatic write_edge(input int k);
		gaa_pkg::sdram_word_t noise;
		noise = gaa_pkg::sdram_word_t'($random(seed));
		u_sdram_model.poke(gaa_pkg::sdram_addr_t'(2 * k), {noise[15:NODE_W], edge_a[k]});
		noise = gaa_pkg::sdram_word_t'($random(seed));
		u_sdram_model.poke(gaa_pkg::sdram_addr_t'(2 * k + 1), {noise[15:NODE_W], edge_b[k]});
	endtask

	task automatic make_edges(input int n);
		edge_total = n;
		for (int k = 0; k < n; k++) begin
			edge_a[k] = NODE_W'($random(seed));
			edge_b[k] = NODE_W'($random(seed));
			write_edge(k);
		end
	endtask

	// individual i is cut by every edge whose end rows disagree in bit i
	task automatic compute_expected();
		for (int i = 0; i < NUM_IDV; i++) begin
			exp_counts[i] = 0;
			for (int k = 0; k < edge_total; k++) begin
				if (pop_rows[edge_a[k]][i] != pop_rows[edge_b[k]][i]) begin
					exp_counts[i]++;
				end
			end
		end
	endtask

	task automatic start_run(input int n_idv);
		preset_results();
		host_write(gaa_pkg::REG_EDGES_LO, gaa_pkg::host_byte_t'(edge_total));
		host_write(gaa_pkg::REG_EDGES_HI, gaa_pkg::host_byte_t'(edge_total >> 8));
		host_write(gaa_pkg::REG_NUM_IDV, gaa_pkg::host_byte_t'(n_idv));
		host_write(gaa_pkg::REG_START, 8'h01);
	endtask

	task automatic wait_done();
		@(negedge clk);
		while (hps_waitrequest) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic check_results(input string name, input int n_idv);
		gaa_pkg::sdram_word_t actual;
		for (int i = 0; i < NUM_IDV + EXTRA_WORDS; i++) begin
			actual = u_sdram_model.peek(FITNESS_BASE + gaa_pkg::sdram_addr_t'(i));
			if (i < n_idv) begin
				check_value($sformatf("%s count %0d", name, i), exp_counts[i], int'(actual));
			end else begin
				check_value($sformatf("%s preset word %0d", name, i),
					int'(preset_word(i)), int'(actual));
			end
		end
	endtask

	task automatic test_reset_regs();
		int err_start;
		gaa_pkg::host_byte_t value;
		err_start = errors;
		check_value("reset_regs waitrequest", 0, int'(hps_waitrequest));
		check_value("reset_regs sdram chipselect", 0, int'(sdram_chipselect));
		check_value("reset_regs sdram read_n", 1, int'(sdram_read_n));
		check_value("reset_regs sdram write_n", 1, int'(sdram_write_n));
		host_write(gaa_pkg::REG_EDGES_LO, 8'h5a);
		host_write(gaa_pkg::REG_EDGES_HI, 8'hc3);
		host_write(gaa_pkg::REG_NUM_IDV, 8'h0b);
		host_read(gaa_pkg::REG_EDGES_LO, value);
		check_value("reset_regs edges lo", 'h5a, int'(value));
		host_read(gaa_pkg::REG_EDGES_HI, value);
		check_value("reset_regs edges hi", 'hc3, int'(value));
		host_read(gaa_pkg::REG_NUM_IDV, value);
		check_value("reset_regs num_idv", 'h0b, int'(value));
		host_read(gaa_pkg::REG_POP_BYTE, value);
		check_value("reset_regs unmapped read", 0, int'(value));
		finish_test("reset_regs", err_start);
	endtask

	task automatic test_single_edge();
		int err_start;
		logic [NUM_IDV-1:0] row_a;
		logic [NUM_IDV-1:0] row_b;
		err_start = errors;
		row_a = NUM_IDV'(16'ha5c3);
		row_b = NUM_IDV'(16'h0ff0);
		random_population();
		pop_rows[5] = row_a;
		pop_rows[9] = row_b;
		load_population();
		edge_total = EDGES_SINGLE;
		edge_a[0] = NODE_W'(5);
		edge_b[0] = NODE_W'(9);
		write_edge(0);
		for (int i = 0; i < NUM_IDV; i++) begin
			exp_counts[i] = int'(row_a[i] ^ row_b[i]);
		end
		start_run(NUM_IDV);
		wait_done();
		check_results("single_edge", NUM_IDV);
		finish_test("single_edge", err_start);
	endtask

	task automatic test_random_graph();
		int err_start;
		err_start = errors;
		random_population();
		load_population();
		make_edges(EDGES_RANDOM);
		compute_expected();
		start_run(NUM_IDV);
		wait_done();
		check_results("random_graph", NUM_IDV);
		finish_test("random_graph", err_start);
	endtask

	// same graph as before, only the first few individuals come back
	task automatic test_partial_writeback();
		int err_start;
		err_start = errors;
		start_run(PARTIAL_IDV);
		wait_done();
		check_results("partial_writeback", PARTIAL_IDV);
		finish_test("partial_writeback", err_start);
	endtask

	task automatic test_random_latency();
		int err_start;
		err_start = errors;
		rand_en = 1'b1;
		start_run(NUM_IDV);
		wait_done();
		rand_en = 1'b0;
		check_results("random_latency", NUM_IDV);
		finish_test("random_latency", err_start);
	endtask

	task automatic test_stall_rerun();
		int err_start;
		gaa_pkg::host_byte_t value;
		err_start = errors;
		make_edges(EDGES_RERUN);
		compute_expected();
		start_run(NUM_IDV);
		// lands while the run is still fetching edges
		host_write(gaa_pkg::REG_NUM_IDV, gaa_pkg::host_byte_t'(PARTIAL_IDV));
		if (stall_cycles <= 2 * edge_total) begin
			$display("stall_rerun: host write went through after %0d stall cycles, %s",
				stall_cycles, "before the run could have ended");
			errors++;
		end
		check_results("stall_rerun", NUM_IDV);
		host_read(gaa_pkg::REG_NUM_IDV, value);
		check_value("stall_rerun num_idv", PARTIAL_IDV, int'(value));
		finish_test("stall_rerun", err_start);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		seed = SEED;
		errors = 0;
		tests_run = 0;
		failed_tests = 0;
		stall_cycles = 0;
		edge_total = 0;
		reset = 1'b1;
		rand_en = 1'b0;
		hps_address = '0;
		hps_chipselect = 1'b0;
		hps_write = 1'b0;
		hps_writedata = '0;
		hps_read = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_regs();
		test_single_edge();
		test_random_graph();
		test_partial_writeback();
		test_random_latency();
		test_stall_rerun();
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, failed_tests, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
